/* Bender.yml */
package:
  name: asym_fifo

dependencies: {}

sources:
  # package first, then interface and leaf modules
  - files:
      - hw/asym_fifo_pkg.sv
      - hw/ext_mem_if.sv
      - hw/ram_2p_bank.sv
      - hw/ram_2p_asym_map.sv
      - hw/asym_fifo_ctrl.sv
      - hw/asym_fifo_top.sv

  # testbench only
  - target: test
    files:
      - verification/tb_asym_fifo.sv

/* hw/asym_fifo_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module asym_fifo_ctrl
   import asym_fifo_pkg::*;
(
   input  wire                 clk_i,
   input  wire                 rst_n_i,

   // producer and consumer strobes
   input  wire                 push_i,
   input  wire [W_DATA_W-1:0]  push_data_i,
   input  wire                 pop_i,

   // logical memory ports
   output logic                mem_w_en_o,
   output logic [W_ADDR_W-1:0] mem_w_addr_o,
   output logic [W_DATA_W-1:0] mem_w_data_o,
   output logic                mem_r_en_o,
   output logic [R_ADDR_W-1:0] mem_r_addr_o,

   // status
   output logic                pop_valid_o,
   output logic                empty_o,
   output logic                full_o,
   output logic [LEVEL_W-1:0]  level_o
);

   logic [W_ADDR_W-1:0] wr_ptr_q;
   logic [R_ADDR_W-1:0] rd_ptr_q;
   logic [LEVEL_W-1:0]  level_q;
   logic [LEVEL_W-1:0]  level_d;
   logic                pop_valid_q;
   logic                push_ok;
   logic                pop_ok;

   // empty means no complete wide word stored yet
   assign empty_o = (level_q < LEVEL_W'(RATIO));
   assign full_o  = (level_q == LEVEL_W'(DEPTH_W));

   // refused strobes are simply dropped
   assign push_ok = push_i & ~full_o;
   assign pop_ok  = pop_i & ~empty_o;

   // a push adds one byte, a pop removes a whole word
   always_comb begin
      level_d = level_q;
      if (push_ok) begin
         level_d = level_d + LEVEL_W'(1);
      end
      if (pop_ok) begin
         level_d = level_d - LEVEL_W'(RATIO);
      end
   end

   // write pointer counts bytes, read pointer counts words
   // both wrap naturally at their widths
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         level_q     <= '0;
         pop_valid_q <= 1'b0;
      end else begin
         if (push_ok) begin
            wr_ptr_q <= wr_ptr_q + W_ADDR_W'(1);
         end
         if (pop_ok) begin
            rd_ptr_q <= rd_ptr_q + R_ADDR_W'(1);
         end
         level_q     <= level_d;
         // banks register the word on the same edge
         pop_valid_q <= pop_ok;
      end
   end

   assign mem_w_en_o   = push_ok;
   assign mem_w_addr_o = wr_ptr_q;
   assign mem_w_data_o = push_data_i;
   assign mem_r_en_o   = pop_ok;
   assign mem_r_addr_o = rd_ptr_q;

   assign pop_valid_o = pop_valid_q;
   assign level_o     = level_q;

   // a push seen while full must not move the write pointer
   a_no_wr_when_full: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) full_o |=> $stable(wr_ptr_q)
   ) else $error("write pointer moved while full");

   a_level_bound: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) level_q <= LEVEL_W'(DEPTH_W)
   ) else $error("level %0d above depth", level_q);

endmodule

`default_nettype wire

/* hw/asym_fifo_pkg.sv */
`default_nettype none

package asym_fifo_pkg;

   // narrow side, one byte per push
   localparam int unsigned W_DATA_W = 8;

   // wide side, one word per pop
   localparam int unsigned R_DATA_W = 32;

   // narrow words per wide word, also the bank count
   localparam int unsigned RATIO = R_DATA_W / W_DATA_W;

   // every bank is as wide as the narrow port
   localparam int unsigned MIN_DATA_W = W_DATA_W;

   // narrow address spans the whole buffer
   localparam int unsigned W_ADDR_W = 6;

   // low narrow-address bits that pick a bank
   localparam int unsigned SEL_W = $clog2(RATIO);

   // wide address, shared by every bank as its own address
   localparam int unsigned R_ADDR_W = W_ADDR_W - SEL_W;

   // capacity counted in narrow words
   localparam int unsigned DEPTH_W = 2 ** W_ADDR_W;

   // fill level must reach DEPTH_W itself, hence one extra bit
   localparam int unsigned LEVEL_W = W_ADDR_W + 1;

endpackage

`default_nettype wire

/* hw/asym_fifo_top.sv */
`timescale 1ns/1ps
`default_nettype none

module asym_fifo_top
   import asym_fifo_pkg::*;
(
   input  wire                 clk_i,
   input  wire                 rst_n_i,

   // producer side, one byte per strobe
   input  wire                 push_i,
   input  wire [W_DATA_W-1:0]  push_data_i,

   // consumer side, one word per strobe
   input  wire                 pop_i,
   output logic [R_DATA_W-1:0] pop_data_o,
   output logic                pop_valid_o,

   // status
   output logic                empty_o,
   output logic                full_o,
   output logic [LEVEL_W-1:0]  level_o
);

   logic                mem_w_en;
   logic [W_ADDR_W-1:0] mem_w_addr;
   logic [W_DATA_W-1:0] mem_w_data;
   logic                mem_r_en;
   logic [R_ADDR_W-1:0] mem_r_addr;

   ext_mem_if bank_bus ();

   asym_fifo_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .push_i       (push_i),
      .push_data_i  (push_data_i),
      .pop_i        (pop_i),
      .mem_w_en_o   (mem_w_en),
      .mem_w_addr_o (mem_w_addr),
      .mem_w_data_o (mem_w_data),
      .mem_r_en_o   (mem_r_en),
      .mem_r_addr_o (mem_r_addr),
      .pop_valid_o  (pop_valid_o),
      .empty_o      (empty_o),
      .full_o       (full_o),
      .level_o      (level_o)
   );

   // byte-wide logical ports onto the bank bus
   ram_2p_asym_map u_map (
      .w_en_i   (mem_w_en),
      .w_addr_i (mem_w_addr),
      .w_data_i (mem_w_data),
      .r_en_i   (mem_r_en),
      .r_addr_i (mem_r_addr),
      .r_data_o (pop_data_o),
      .mem      (bank_bus.ctrl)
   );

   // one bank per byte lane
   for (genvar g = 0; g < RATIO; g++) begin : g_bank
      ram_2p_bank #(
         .LANE (g)
      ) u_bank (
         .clk_i (clk_i),
         .mem   (bank_bus.bank)
      );
   end

endmodule

`default_nettype wire

/* hw/ext_mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ext_mem_if
   import asym_fifo_pkg::*;
();

   // write side, one lane per bank
   logic [RATIO-1:0]                 w_en;
   logic [RATIO-1:0][R_ADDR_W-1:0]   w_addr;
   logic [RATIO-1:0][MIN_DATA_W-1:0] w_data;

   // read side, enable is common to all banks
   logic                             r_en;
   logic [RATIO-1:0][R_ADDR_W-1:0]   r_addr;

   // each bank drives only its own lane
   wire  [RATIO-1:0][MIN_DATA_W-1:0] r_data;

   // address mapper side
   modport ctrl (
      output w_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   // memory bank side
   modport bank (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

`default_nettype wire

/* hw/ram_2p_asym_map.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_2p_asym_map
   import asym_fifo_pkg::*;
(
   // narrow write port
   input  wire                 w_en_i,
   input  wire [W_ADDR_W-1:0]  w_addr_i,
   input  wire [W_DATA_W-1:0]  w_data_i,

   // wide read port
   input  wire                 r_en_i,
   input  wire [R_ADDR_W-1:0]  r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o,

   // towards the banks
   ext_mem_if.ctrl             mem
);

   logic [SEL_W-1:0]    w_sel;
   logic [R_ADDR_W-1:0] w_row;
   logic [RATIO-1:0]    w_dec;

   // low bits pick the bank, the rest is the row inside it
   assign w_sel = w_addr_i[SEL_W-1:0];
   assign w_row = w_addr_i[W_ADDR_W-1:SEL_W];

   always_comb begin
      w_dec = '0;
      if (w_en_i) begin
         w_dec[w_sel] = 1'b1;
      end
   end

   assign mem.w_en = w_dec;

   // all banks read the same row at once
   assign mem.r_en = r_en_i;

   for (genvar q = 0; q < RATIO; q++) begin : g_lane
      // data and row go everywhere, only the enable is decoded
      assign mem.w_data[q] = w_data_i;
      assign mem.w_addr[q] = w_row;
      assign mem.r_addr[q] = r_addr_i;

      // bank q lands in byte q, first pushed byte ends up lowest
      assign r_data_o[q*MIN_DATA_W +: MIN_DATA_W] = mem.r_data[q];
   end

endmodule

`default_nettype wire

/* hw/ram_2p_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_2p_bank
   import asym_fifo_pkg::*;
#(
   parameter int unsigned LANE = 0
) (
   input wire     clk_i,
   ext_mem_if.bank mem
);

   logic [MIN_DATA_W-1:0] ram_q [2**R_ADDR_W];
   logic [MIN_DATA_W-1:0] rd_data_q;

   // write port, this lane only
   always_ff @(posedge clk_i) begin
      if (mem.w_en[LANE]) begin
         ram_q[mem.w_addr[LANE]] <= mem.w_data[LANE];
      end
   end

   // read port
   // output holds until the next enabled read
   always_ff @(posedge clk_i) begin
      if (mem.r_en) begin
         rd_data_q <= ram_q[mem.r_addr[LANE]];
      end
   end

   assign mem.r_data[LANE] = rd_data_q;

   // an X address here would corrupt a whole wide word
   a_rd_addr_known: assert property (
      @(posedge clk_i) mem.r_en |-> !$isunknown(mem.r_addr[LANE])
   ) else $error("bank %0d read with unknown address", LANE);

endmodule

`default_nettype wire

/* tb.f */
hw/asym_fifo_pkg.sv
hw/ext_mem_if.sv
hw/ram_2p_bank.sv
hw/ram_2p_asym_map.sv
hw/asym_fifo_ctrl.sv
hw/asym_fifo_top.sv
verification/tb_asym_fifo.sv

/* verification/tb_asym_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_asym_fifo;

   localparam int CLK_HALF       = 10;
   localparam int RST_CYCLES     = 8;
   localparam int VALID_TIMEOUT  = 10;
   localparam int MAX_BYTES      = 64;
   localparam int BYTES_PER_WORD = 4;
   localparam int RANDOM_ROWS    = 400;

   logic        clk;
   logic        rst_n;
   logic        push;
   logic [7:0]  push_data;
   logic        pop;
   logic [31:0] pop_data;
   logic        pop_valid;
   logic        empty;
   logic        full;
   logic [6:0]  level;

   // stimulus table, one entry per row in each queue
   string       row_name[$];
   bit          row_push[$];
   logic [7:0]  row_byte[$];
   bit          row_rnd[$];
   bit          row_pop[$];
   int          row_level[$];

   // reference byte queue, oldest byte at the front
   logic [7:0]  model_q[$];

   int          table_level;
   int          errors;
   int          checks;

   asym_fifo_top u_asym_fifo_top (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .push_i      (push),
      .push_data_i (push_data),
      .pop_i       (pop),
      .pop_data_o  (pop_data),
      .pop_valid_o (pop_valid),
      .empty_o     (empty),
      .full_o      (full),
      .level_o     (level)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // appends a row and works out the level it should leave behind
   task automatic add_row(input string name, input bit do_push, input logic [7:0] data,
                          input bit rnd, input bit do_pop);
      bit push_ok;
      bit pop_ok;
      push_ok = do_push && (table_level < MAX_BYTES);
      pop_ok  = do_pop && (table_level >= BYTES_PER_WORD);
      if (push_ok) begin
         table_level = table_level + 1;
      end
      if (pop_ok) begin
         table_level = table_level - BYTES_PER_WORD;
      end
      row_name.push_back(name);
      row_push.push_back(do_push);
      row_byte.push_back(data);
      row_rnd.push_back(rnd);
      row_pop.push_back(do_pop);
      row_level.push_back(table_level);
   endtask

   task automatic report_mismatch(input string name, input string what,
                                  input logic [31:0] exp, input logic [31:0] act);
      errors = errors + 1;
      $display("ERR %s %s: expected 0x%0h, actual 0x%0h", name, what, exp, act);
   endtask

   task automatic build_table();
      int i;
      // one wide word of known bytes
      add_row("word_b0", 1'b1, 8'h11, 1'b0, 1'b0);
      add_row("word_b1", 1'b1, 8'h22, 1'b0, 1'b0);
      add_row("word_b2", 1'b1, 8'h33, 1'b0, 1'b0);
      add_row("word_b3", 1'b1, 8'h44, 1'b0, 1'b0);
      add_row("word_pop", 1'b0, 8'h00, 1'b0, 1'b1);
      // fill to the brim, then one push too many
      for (i = 0; i < MAX_BYTES; i++) begin
         add_row($sformatf("fill_%0d", i), 1'b1, 8'(i), 1'b0, 1'b0);
      end
      add_row("push_when_full", 1'b1, 8'hA5, 1'b0, 1'b0);
      for (i = 0; i < MAX_BYTES / BYTES_PER_WORD; i++) begin
         add_row($sformatf("drain_%0d", i), 1'b0, 8'h00, 1'b0, 1'b1);
      end
      // three bytes are not a word yet
      add_row("short_b0", 1'b1, 8'hC0, 1'b0, 1'b0);
      add_row("short_b1", 1'b1, 8'hC1, 1'b0, 1'b0);
      add_row("short_b2", 1'b1, 8'hC2, 1'b0, 1'b0);
      add_row("pop_short", 1'b0, 8'h00, 1'b0, 1'b1);
      add_row("short_b3", 1'b1, 8'hC3, 1'b0, 1'b0);
      add_row("push_and_pop", 1'b1, 8'hD0, 1'b0, 1'b1);
      // random mix, long enough to wrap both pointers
      for (i = 0; i < RANDOM_ROWS; i++) begin
         add_row($sformatf("rand_%0d", i), ($urandom % 8) < 5, 8'h00, 1'b1,
                 ($urandom % 5) == 0);
      end
      while (table_level >= BYTES_PER_WORD) begin
         add_row("final_drain", 1'b0, 8'h00, 1'b0, 1'b1);
      end
   endtask

   task automatic check_reset();
      int i;
      @(negedge clk);
      if (empty !== 1'b1) report_mismatch("reset", "empty", 1, empty);
      if (full !== 1'b0) report_mismatch("reset", "full", 0, full);
      if (level !== 7'd0) report_mismatch("reset", "level", 0, level);
      checks = checks + 3;
      // no stray valid pulse while idle
      for (i = 0; i < 4; i++) begin
         checks = checks + 1;
         if (pop_valid !== 1'b0) report_mismatch("reset", "pop_valid", 0, pop_valid);
         @(negedge clk);
      end
   endtask

   task automatic apply_row(input int idx);
      logic [7:0]  data;
      logic [31:0] exp_word;
      bit          push_ok;
      bit          pop_ok;
      bit          exp_empty;
      bit          exp_full;
      int          k;
      int          waited;
      data     = row_rnd[idx] ? 8'($urandom) : row_byte[idx];
      push_ok  = row_push[idx] && (model_q.size() < MAX_BYTES);
      pop_ok   = row_pop[idx] && (model_q.size() >= BYTES_PER_WORD);
      exp_word = '0;
      @(posedge clk);
      push      <= row_push[idx];
      push_data <= data;
      pop       <= row_pop[idx];
      @(posedge clk);
      push <= 1'b0;
      pop  <= 1'b0;
      // the pop takes the four oldest bytes, oldest lowest
      if (pop_ok) begin
         for (k = 0; k < BYTES_PER_WORD; k++) begin
            exp_word[8*k +: 8] = model_q.pop_front();
         end
      end
      if (push_ok) begin
         model_q.push_back(data);
      end
      exp_empty = model_q.size() < BYTES_PER_WORD;
      exp_full  = model_q.size() == MAX_BYTES;
      @(negedge clk);
      checks = checks + 4;
      if (level !== 7'(row_level[idx])) begin
         report_mismatch(row_name[idx], "level", row_level[idx], level);
      end
      if (level !== 7'(model_q.size())) begin
         report_mismatch(row_name[idx], "level vs model", model_q.size(), level);
      end
      if (empty !== exp_empty) report_mismatch(row_name[idx], "empty", exp_empty, empty);
      if (full !== exp_full) report_mismatch(row_name[idx], "full", exp_full, full);
      if (pop_ok) begin
         waited = 0;
         while (pop_valid !== 1'b1 && waited < VALID_TIMEOUT) begin
            @(negedge clk);
            waited = waited + 1;
         end
         checks = checks + 1;
         if (pop_valid !== 1'b1) begin
            errors = errors + 1;
            $display("row %s: pop data never became valid", row_name[idx]);
         end else if (pop_data !== exp_word) begin
            report_mismatch(row_name[idx], "pop_data", exp_word, pop_data);
         end
      end else begin
         checks = checks + 1;
         if (pop_valid !== 1'b0) begin
            errors = errors + 1;
            $display("row %s: pop valid pulsed without an accepted pop", row_name[idx]);
         end
      end
   endtask

   initial begin
      int i;
      void'($urandom(61));
      errors      = 0;
      checks      = 0;
      table_level = 0;
      rst_n     <= 1'b0;
      push      <= 1'b0;
      push_data <= 8'h00;
      pop       <= 1'b0;
      build_table();
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      check_reset();
      for (i = 0; i < row_name.size(); i++) begin
         apply_row(i);
      end
      $display("rows: %0d, checks: %0d, errors: %0d", row_name.size(), checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
